// File: sim/dmem_init.hex
// bytes in rising address order, @ lines set the address
// 0x00 words, 0x08 signed data, 0x0c store area, 0x80 and 0x100 protect tests, top bytes
@00000000
78 56 34 12
f0 de bc 9a
81 7f ff 80
55 66 77 88
01 02 03 04
@00000080
a1 b2 c3 d4
@00000100
10 20 30 40
@0001fffe
5a a5

// File: dmem_sub.f
+incdir+sim
hw/dmem_geom_pkg.sv
hw/dmem_bus_pkg.sv
hw/data_mem.sv
hw/lsu_req_queue.sv
hw/dmem_ctrl.sv
hw/dmem_csr.sv
hw/dmem_top.sv
sim/dmem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run from the project root, the memory image path is relative to it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module dmem_tb -f dmem_sub.f -o dmem_sim \
    && ./obj_dir/dmem_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/dmem_tb_table.svh
`ifndef DMEM_TB_TABLE_SVH
`define DMEM_TB_TABLE_SVH

// one row per request, register access optional around it
typedef struct packed {
    logic      cfg_wr;     // register write before the request
    csr_idx_t  cfg_idx;
    word_t     cfg_wdata;
    dmem_req_t req;
    dmem_rsp_t exp;
    logic      rb_en;      // register readback once the response is in
    csr_idx_t  rb_idx;
    word_t     rb_val;
} row_t;

row_t  rows  [$];
string names [$];

function automatic dmem_req_t load_req(input logic sgn, input access_size_e size,
                                       input addr_t addr);
    return '{write: 1'b0, sign: sgn, size: size, addr: addr, wdata: '0};
endfunction

function automatic dmem_req_t store_req(input access_size_e size, input addr_t addr,
                                        input word_t wdata);
    return '{write: 1'b1, sign: 1'b0, size: size, addr: addr, wdata: wdata};
endfunction

// flags are {err_range, err_protect}
function automatic void add_row(input string name, input dmem_req_t req, input word_t data,
                                input logic [1:0] flags);
    row_t r;
    r     = '0;
    r.req = req;
    r.exp = '{data: data, err_range: flags[1], err_protect: flags[0]};
    rows.push_back(r);
    names.push_back(name);
endfunction

function automatic void with_cfg_write(input csr_idx_t idx, input word_t value);
    row_t r;
    r           = rows[rows.size() - 1];
    r.cfg_wr    = 1'b1;
    r.cfg_idx   = idx;
    r.cfg_wdata = value;
    rows[rows.size() - 1] = r;
endfunction

function automatic void with_readback(input csr_idx_t idx, input word_t value);
    row_t r;
    r        = rows[rows.size() - 1];
    r.rb_en  = 1'b1;
    r.rb_idx = idx;
    r.rb_val = value;
    rows[rows.size() - 1] = r;
endfunction

function automatic void fill_table();
    // loads from the image
    add_row("ld_word_0", load_req(1'b0, SIZE_WORD, 32'h00000000), 32'h12345678, 2'b00);
    add_row("ld_half_2", load_req(1'b0, SIZE_HALF, 32'h00000002), 32'h00001234, 2'b00);
    add_row("ld_byte_5", load_req(1'b0, SIZE_BYTE, 32'h00000005), 32'h000000de, 2'b00);
    add_row("ld_word_4", load_req(1'b0, SIZE_WORD, 32'h00000004), 32'h9abcdef0, 2'b00);
    // stores hand back the old bytes
    add_row("st_byte_c", store_req(SIZE_BYTE, 32'h0000000c, 32'h000000ee), 32'h00000055, 2'b00);
    add_row("st_half_e", store_req(SIZE_HALF, 32'h0000000e, 32'h0000bbcc), 32'h00008877, 2'b00);
    add_row("ld_word_c", load_req(1'b0, SIZE_WORD, 32'h0000000c), 32'hbbcc66ee, 2'b00);
    add_row("st_word_10", store_req(SIZE_WORD, 32'h00000010, 32'hcafef00d), 32'h04030201, 2'b00);
    add_row("ld_half_12", load_req(1'b0, SIZE_HALF, 32'h00000012), 32'h0000cafe, 2'b00);
    add_row("ld_byte_11", load_req(1'b0, SIZE_BYTE, 32'h00000011), 32'h000000f0, 2'b00);
    // signed against unsigned
    add_row("lds_byte_8", load_req(1'b1, SIZE_BYTE, 32'h00000008), 32'hffffff81, 2'b00);
    add_row("ldu_byte_8", load_req(1'b0, SIZE_BYTE, 32'h00000008), 32'h00000081, 2'b00);
    add_row("lds_byte_9", load_req(1'b1, SIZE_BYTE, 32'h00000009), 32'h0000007f, 2'b00);
    add_row("lds_half_a", load_req(1'b1, SIZE_HALF, 32'h0000000a), 32'hffff80ff, 2'b00);
    add_row("ldu_half_a", load_req(1'b0, SIZE_HALF, 32'h0000000a), 32'h000080ff, 2'b00);
    // top of memory
    add_row("rng_word", load_req(1'b0, SIZE_WORD, 32'h0001fffd), ERROR_WORD, 2'b10);
    with_readback(CSR_ERR_COUNT, 32'd1);
    add_row("rng_half_ok", load_req(1'b0, SIZE_HALF, 32'h0001fffe), 32'h0000a55a, 2'b00);
    with_readback(CSR_LAST_ERR_ADDR, 32'h0001fffd);
    add_row("rng_byte", load_req(1'b0, SIZE_BYTE, 32'h00020000), ERROR_WORD, 2'b10);
    with_readback(CSR_ERR_COUNT, 32'd2);
    add_row("ld_after_rng", load_req(1'b0, SIZE_WORD, 32'h00000000), 32'h12345678, 2'b00);
    with_readback(CSR_LAST_ERR_ADDR, 32'h00020000);
    add_row("clr_count", load_req(1'b0, SIZE_WORD, 32'h00000004), 32'h9abcdef0, 2'b00);
    with_cfg_write(CSR_ERR_COUNT, 32'h0);
    with_readback(CSR_ERR_COUNT, 32'd0);
    add_row("rng_sbyte", load_req(1'b1, SIZE_BYTE, 32'h00020001), ERROR_WORD, 2'b10);
    with_readback(CSR_ERR_COUNT, 32'd1);
    // store protection
    add_row("prot_store", store_req(SIZE_WORD, 32'h00000080, 32'h11111111), 32'hd4c3b2a1, 2'b01);
    with_cfg_write(CSR_PROTECT_LIMIT, 32'h00000100);
    with_readback(CSR_ERR_COUNT, 32'd2);
    add_row("prot_check", load_req(1'b0, SIZE_WORD, 32'h00000080), 32'hd4c3b2a1, 2'b00);
    with_readback(CSR_PROTECT_LIMIT, 32'h00000100);
    add_row("st_at_limit", store_req(SIZE_WORD, 32'h00000100, 32'h600df00d), 32'h40302010, 2'b00);
    add_row("ld_at_limit", load_req(1'b0, SIZE_WORD, 32'h00000100), 32'h600df00d, 2'b00);
    with_readback(CSR_LAST_ERR_ADDR, 32'h00000080);
    // burst past the queue depth
    add_row("burst_0", load_req(1'b0, SIZE_BYTE, 32'h00000000), 32'h00000078, 2'b00);
    add_row("burst_1", load_req(1'b0, SIZE_BYTE, 32'h00000001), 32'h00000056, 2'b00);
    add_row("burst_2", load_req(1'b0, SIZE_BYTE, 32'h00000002), 32'h00000034, 2'b00);
    add_row("burst_3", load_req(1'b0, SIZE_BYTE, 32'h00000003), 32'h00000012, 2'b00);
    add_row("burst_4", store_req(SIZE_HALF, 32'h00000100, 32'h00001234), 32'h0000f00d, 2'b00);
    add_row("burst_5", load_req(1'b0, SIZE_WORD, 32'h00000100), 32'h600d1234, 2'b00);
    add_row("burst_6", load_req(1'b1, SIZE_HALF, 32'h00000102), 32'h0000600d, 2'b00);
    add_row("burst_7", load_req(1'b0, SIZE_WORD, 32'h00000010), 32'hcafef00d, 2'b00);
endfunction

`endif

// File: sim/dmem_tb.sv
`timescale 1ns/1ps

module dmem_tb
    import dmem_geom_pkg::*;
    import dmem_bus_pkg::*;
();

    logic      clk = 1'b0;
    logic      rst_n_i;
    logic      req_valid_i;
    dmem_req_t req_i;
    logic      req_credit_o;
    logic      rsp_valid_o;
    dmem_rsp_t rsp_o;
    logic      rsp_credit_i = 1'b0;
    logic      cfg_wr_i;
    csr_idx_t  cfg_idx_i;
    word_t     cfg_wdata_i;
    word_t     cfg_rdata_o;

    int errors          = 0;
    int rsp_count       = 0;            // responses checked so far
    int req_credits     = REQ_CREDITS;  // held by the requester
    int reqs_sent       = 0;
    int credits_back    = 0;
    int rsp_outstanding = 0;            // responses not yet credited back
    int credit_delays [$];

    `include "dmem_tb_table.svh"

    dmem_top u_dut (.*);

    always #50 clk = ~clk;

    task automatic send_request(input dmem_req_t req);
        @(posedge clk);
        while (req_credits == 0) begin  // stall until the queue frees an entry
            req_valid_i <= 1'b0;
            @(posedge clk);
        end
        req_valid_i <= 1'b1;
        req_i       <= req;
        req_credits--;
    endtask

    task automatic wait_responses(input int n);
        int waited;
        waited = 0;
        @(posedge clk);
        req_valid_i <= 1'b0;
        while (rsp_count < n && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        assert (rsp_count >= n) else begin
            errors++;
            $display("missing response: only %0d of %0d arrived", rsp_count, n);
        end
        repeat (2) @(posedge clk);  // error event reaches the register block
    endtask

    task automatic write_csr(input csr_idx_t idx, input word_t value);
        @(posedge clk);
        cfg_wr_i    <= 1'b1;
        cfg_idx_i   <= idx;
        cfg_wdata_i <= value;
        @(posedge clk);
        cfg_wr_i    <= 1'b0;
    endtask

    task automatic read_csr(input string name, input csr_idx_t idx, input word_t exp_val);
        @(posedge clk);
        cfg_idx_i <= idx;
        @(negedge clk);
        assert (cfg_rdata_o == exp_val) else begin
            errors++;
            $display("CHECK FAILED %s csr %0d: expected %h, actual %h",
                     name, idx, exp_val, cfg_rdata_o);
        end
    endtask

    task automatic check_response();
        dmem_rsp_t expected;
        assert (rsp_count < rows.size()) else begin
            errors++;
            $display("response arrived with no request left in the table");
            return;
        end
        expected = rows[rsp_count].exp;
        assert (rsp_o == expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h range %b prot %b, actual %h range %b prot %b",
                     names[rsp_count], expected.data, expected.err_range, expected.err_protect,
                     rsp_o.data, rsp_o.err_range, rsp_o.err_protect);
        end
        rsp_count++;
        rsp_outstanding++;
        assert (rsp_outstanding <= RSP_CREDITS) else begin
            errors++;
            $display("more than %0d responses outstanding", RSP_CREDITS);
        end
        credit_delays.push_back(int'($urandom % 6));
    endtask

    // outputs sampled on the falling edge
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (rsp_valid_o) begin
                check_response();
            end
            if (req_valid_i) begin
                reqs_sent++;
            end
            if (req_credit_o) begin
                credits_back++;
                req_credits++;
            end
            // a credit runs ahead of its response only while the entry is in the memory stage
            assert (credits_back - rsp_count <= RSP_CREDITS) else begin
                errors++;
                $display("request issued without a credit: %0d credits back for %0d responses",
                         credits_back, rsp_count);
            end
            assert (credits_back <= reqs_sent) else begin
                errors++;
                $display("request credit returned with no request behind it");
            end
        end
    end

    // drained responses give their credit back after a random delay
    always @(posedge clk) begin
        rsp_credit_i <= 1'b0;
        if (credit_delays.size() > 0) begin
            if (credit_delays[0] == 0) begin
                rsp_credit_i <= 1'b1;
                void'(credit_delays.pop_front());
                rsp_outstanding--;
            end else begin
                credit_delays[0]--;
            end
        end
    end

    initial begin
        @(posedge rst_n_i);
        repeat (20 * rows.size()) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles after reset", 20 * rows.size());
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h78b45abb));
        rst_n_i     <= 1'b0;
        req_valid_i <= 1'b0;
        req_i       <= '0;
        cfg_wr_i    <= 1'b0;
        cfg_idx_i   <= CSR_PROTECT_LIMIT;
        cfg_wdata_i <= '0;
        fill_table();
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].cfg_wr) begin
                wait_responses(i);  // register write only on a quiet pipeline
                write_csr(rows[i].cfg_idx, rows[i].cfg_wdata);
            end
            send_request(rows[i].req);
            if (rows[i].rb_en) begin
                wait_responses(i + 1);
                read_csr(names[i], rows[i].rb_idx, rows[i].rb_val);
            end
        end
        wait_responses(rows.size());
        repeat (8) @(posedge clk);
        $display("dmem_tb: %0d of %0d responses checked, %0d errors",
                 rsp_count, rows.size(), errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: hw/dmem_top.sv
`timescale 1ns/1ps

module dmem_top
    import dmem_geom_pkg::*;
    import dmem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      req_valid_i,
    input  dmem_req_t req_i,
    output logic      req_credit_o,
    output logic      rsp_valid_o,
    output dmem_rsp_t rsp_o,
    input  logic      rsp_credit_i,
    input  logic      cfg_wr_i,
    input  csr_idx_t  cfg_idx_i,
    input  word_t     cfg_wdata_i,
    output word_t     cfg_rdata_o
);

    // queue to controller
    dmem_req_t    head;
    logic         not_empty;
    logic         pop;

    // controller to memory
    logic         acc_valid;
    logic         acc_wr;
    access_size_e acc_size;
    addr_t        acc_addr;
    word_t        acc_wdata;
    word_t        rd_data;
    logic         range_err;

    // controller and register block
    logic         err_event;
    addr_t        err_addr;
    addr_t        protect_limit;

    lsu_req_queue u_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .pop_i        (pop),
        .head_o       (head),
        .not_empty_o  (not_empty),
        .req_credit_o (req_credit_o)
    );

    dmem_ctrl u_ctrl (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .head_i          (head),
        .not_empty_i     (not_empty),
        .pop_o           (pop),
        .rsp_credit_i    (rsp_credit_i),
        .protect_limit_i (protect_limit),
        .acc_valid_o     (acc_valid),
        .acc_wr_o        (acc_wr),
        .acc_size_o      (acc_size),
        .acc_addr_o      (acc_addr),
        .acc_wdata_o     (acc_wdata),
        .rd_data_i       (rd_data),
        .range_err_i     (range_err),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_o           (rsp_o),
        .err_event_o     (err_event),
        .err_addr_o      (err_addr)
    );

    dmem_csr u_csr (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .cfg_wr_i        (cfg_wr_i),
        .cfg_idx_i       (cfg_idx_i),
        .cfg_wdata_i     (cfg_wdata_i),
        .cfg_rdata_o     (cfg_rdata_o),
        .err_event_i     (err_event),
        .err_addr_i      (err_addr),
        .protect_limit_o (protect_limit)
    );

    data_mem u_mem (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .acc_valid_i (acc_valid),
        .acc_wr_i    (acc_wr),
        .acc_size_i  (acc_size),
        .acc_addr_i  (acc_addr),
        .acc_wdata_i (acc_wdata),
        .rd_data_o   (rd_data),
        .range_err_o (range_err)
    );

endmodule

// File: hw/dmem_csr.sv
`timescale 1ns/1ps

module dmem_csr
    import dmem_geom_pkg::*;
    import dmem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     cfg_wr_i,
    input  csr_idx_t cfg_idx_i,
    input  word_t    cfg_wdata_i,
    output word_t    cfg_rdata_o,
    input  logic     err_event_i,
    input  addr_t    err_addr_i,
    output addr_t    protect_limit_o
);

    addr_t protect_limit;
    word_t err_count;
    addr_t last_err_addr;
    logic  clr_count;

    // any write to the count index clears it
    assign clr_count = cfg_wr_i && (cfg_idx_i == CSR_ERR_COUNT);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            protect_limit <= '0;
        end else if (cfg_wr_i && (cfg_idx_i == CSR_PROTECT_LIMIT)) begin
            protect_limit <= cfg_wdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_count <= '0;
        end else if (clr_count) begin
            err_count <= err_event_i ? word_t'(1) : '0;  // event in the clear cycle still counts
        end else if (err_event_i && (err_count != '1)) begin
            err_count <= err_count + word_t'(1);  // saturates at all ones
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_err_addr <= '0;
        end else if (err_event_i) begin
            last_err_addr <= err_addr_i;
        end
    end

    // read mux, index 3 reads zero
    always_comb begin
        case (cfg_idx_i)
            CSR_PROTECT_LIMIT: cfg_rdata_o = protect_limit;
            CSR_ERR_COUNT:     cfg_rdata_o = err_count;
            CSR_LAST_ERR_ADDR: cfg_rdata_o = last_err_addr;
            default:           cfg_rdata_o = '0;
        endcase
    end

    assign protect_limit_o = protect_limit;

endmodule

// File: hw/dmem_ctrl.sv
`timescale 1ns/1ps

module dmem_ctrl
    import dmem_geom_pkg::*;
    import dmem_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  dmem_req_t    head_i,
    input  logic         not_empty_i,
    output logic         pop_o,
    input  logic         rsp_credit_i,
    input  addr_t        protect_limit_i,
    output logic         acc_valid_o,
    output logic         acc_wr_o,
    output access_size_e acc_size_o,
    output addr_t        acc_addr_o,
    output word_t        acc_wdata_o,
    input  word_t        rd_data_i,
    input  logic         range_err_i,
    output logic         rsp_valid_o,
    output dmem_rsp_t    rsp_o,
    output logic         err_event_o,
    output addr_t        err_addr_o
);

    typedef logic [$clog2(RSP_CREDITS+1)-1:0] credit_t;

    // ISSUE_ACTIVE means an access sits in the memory stage
    typedef enum logic {
        ISSUE_IDLE,
        ISSUE_ACTIVE
    } issue_state_e;

    issue_state_e state;
    credit_t      credits;
    logic         issue;
    logic         protect_hit;
    word_t        rsp_data;

    // memory stage payload
    logic         p_sext;
    access_size_e p_size;
    logic         p_prot;
    addr_t        p_addr;

    assign issue       = not_empty_i && (credits != '0);
    assign protect_hit = head_i.write && (head_i.addr < protect_limit_i);

    assign pop_o       = issue;
    assign acc_valid_o = issue;
    assign acc_wr_o    = head_i.write && !protect_hit;  // protected store becomes a read
    assign acc_size_o  = head_i.size;
    assign acc_addr_o  = head_i.addr;
    assign acc_wdata_o = head_i.wdata;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credits <= credit_t'(RSP_CREDITS);
            state   <= ISSUE_IDLE;
        end else begin
            credits <= credits + credit_t'(rsp_credit_i) - credit_t'(issue);
            state   <= issue ? ISSUE_ACTIVE : ISSUE_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            p_sext <= head_i.sign && !head_i.write;  // only loads extend
            p_size <= head_i.size;
            p_prot <= protect_hit;
            p_addr <= head_i.addr;
        end
    end

    // error word passes through untouched
    always_comb begin
        rsp_data = rd_data_i;
        if (p_sext && !range_err_i) begin
            case (p_size)
                SIZE_BYTE: rsp_data = {{24{rd_data_i[7]}}, rd_data_i[7:0]};
                SIZE_HALF: rsp_data = {{16{rd_data_i[15]}}, rd_data_i[15:0]};
                default:   rsp_data = rd_data_i;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
            err_event_o <= 1'b0;
        end else begin
            rsp_valid_o <= state == ISSUE_ACTIVE;
            err_event_o <= (state == ISSUE_ACTIVE) && (range_err_i || p_prot);
        end
    end

    always_ff @(posedge clk) begin
        if (state == ISSUE_ACTIVE) begin
            rsp_o      <= '{data: rsp_data, err_range: range_err_i, err_protect: p_prot};
            err_addr_o <= p_addr;
        end
    end

endmodule

// File: hw/lsu_req_queue.sv
`timescale 1ns/1ps

module lsu_req_queue
    import dmem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      req_valid_i,
    input  dmem_req_t req_i,
    input  logic      pop_i,
    output dmem_req_t head_o,
    output logic      not_empty_o,
    output logic      req_credit_o
);

    typedef logic [$clog2(REQ_CREDITS)-1:0]   ptr_t;
    typedef logic [$clog2(REQ_CREDITS+1)-1:0] cnt_t;

    dmem_req_t entries [REQ_CREDITS];
    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    cnt_t      count;

    // requester holds a credit for every push, so no overflow check
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            entries[wr_ptr] <= req_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid_i) begin
                wr_ptr <= (wr_ptr == ptr_t'(REQ_CREDITS - 1)) ? '0 : wr_ptr + ptr_t'(1);
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == ptr_t'(REQ_CREDITS - 1)) ? '0 : rd_ptr + ptr_t'(1);
            end
            case ({req_valid_i, pop_i})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

    // every released entry hands one credit back
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_credit_o <= 1'b0;
        end else begin
            req_credit_o <= pop_i;
        end
    end

    assign head_o      = entries[rd_ptr];
    assign not_empty_o = count != '0;

endmodule

// File: hw/data_mem.sv
`timescale 1ns/1ps

module data_mem
    import dmem_geom_pkg::*;
    import dmem_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         acc_valid_i,
    input  logic         acc_wr_i,
    input  access_size_e acc_size_i,
    input  addr_t        acc_addr_i,
    input  word_t        acc_wdata_i,
    output word_t        rd_data_o,
    output logic         range_err_o
);

    typedef logic [$clog2(MEM_BYTES)-1:0] mem_idx_t;

    byte_t    mem [MEM_BYTES];
    mem_idx_t base;
    logic [1:0]  span;       // bytes past the first one
    logic [32:0] last_addr;  // one extra bit so a wrap still counts as out of range
    logic        range_err;
    word_t       old_data;

    initial begin
        $readmemh("sim/dmem_init.hex", mem);
    end

    assign base = acc_addr_i[$clog2(MEM_BYTES)-1:0];

    always_comb begin
        case (acc_size_i)
            SIZE_BYTE: span = 2'd0;
            SIZE_HALF: span = 2'd1;
            default:   span = 2'd3;
        endcase
    end

    assign last_addr = {1'b0, acc_addr_i} + 33'(span);
    assign range_err = last_addr > {1'b0, TOP_ADDR};

    // old contents, zero-extended to the access size
    always_comb begin
        case (acc_size_i)
            SIZE_BYTE: old_data = {24'b0, mem[base]};
            SIZE_HALF: old_data = {16'b0, mem[base + mem_idx_t'(1)], mem[base]};
            default:   old_data = {mem[base + mem_idx_t'(3)], mem[base + mem_idx_t'(2)],
                                   mem[base + mem_idx_t'(1)], mem[base]};
        endcase
    end

    // little-endian sized store
    always_ff @(posedge clk) begin
        if (acc_valid_i && acc_wr_i && !range_err) begin
            for (int i = 0; i < 4; i++) begin
                if (i <= int'(span)) begin
                    mem[base + mem_idx_t'(i)] <= acc_wdata_i[8*i +: 8];
                end
            end
        end
    end

    // read port, one cycle behind the access
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o   <= '0;
            range_err_o <= 1'b0;
        end else if (acc_valid_i) begin
            rd_data_o   <= range_err ? ERROR_WORD : old_data;
            range_err_o <= range_err;
        end
    end

endmodule

// File: hw/dmem_bus_pkg.sv
package dmem_bus_pkg;

    import dmem_geom_pkg::*;

    // size of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // request from the core side, 68 bits
    typedef struct packed {
        logic         write;   // store when set, load otherwise
        logic         sign;    // sign-extend narrow loads
        access_size_e size;
        addr_t        addr;
        word_t        wdata;
    } dmem_req_t;

    // response to the core side, 34 bits
    typedef struct packed {
        word_t data;         // load data or old contents on a store
        logic  err_range;    // access ran past TOP_ADDR
        logic  err_protect;  // store suppressed by the protect limit
    } dmem_rsp_t;

    // credit pools
    localparam int REQ_CREDITS = 4;  // request queue depth
    localparam int RSP_CREDITS = 2;  // requester response buffer depth

    // register map of the config port
    typedef logic [1:0] csr_idx_t;

    localparam csr_idx_t CSR_PROTECT_LIMIT = 2'd0;
    localparam csr_idx_t CSR_ERR_COUNT     = 2'd1;
    localparam csr_idx_t CSR_LAST_ERR_ADDR = 2'd2;

endpackage

// File: hw/dmem_geom_pkg.sv
package dmem_geom_pkg;

    // plain vector types for the memory map
    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] word_t;   // data word
    typedef logic [7:0]  byte_t;   // storage unit

    // 128 KiB data memory starting at byte 0
    localparam int    MEM_BYTES  = 131072;
    localparam addr_t TOP_ADDR   = 32'h0001FFFF;  // last valid byte

    // returned in place of data on an out-of-range access
    localparam word_t ERROR_WORD = 32'hDEADBEEF;

endpackage
